// File: rmt_pkg.sv
// rmt action stage definitions
package rmt_pkg;

    // phv geometry
    localparam int NUM_CONT = 4;
    localparam int CONT_W   = 48;

    // sub-action fields, msb first: opcode, select a, select b, immediate
    localparam int ACTION_W = 25;
    localparam int OPCODE_W = 4;
    localparam int SEL_W    = 2;
    localparam int IMM_W    = 17;

    // opcode encodings, the alias codes behave like the base codes
    localparam logic [OPCODE_W-1:0] OP_ADD       = 4'b0001;
    localparam logic [OPCODE_W-1:0] OP_ADD_ALIAS = 4'b1001;
    localparam logic [OPCODE_W-1:0] OP_SUB       = 4'b0010;
    localparam logic [OPCODE_W-1:0] OP_SUB_ALIAS = 4'b1010;
    localparam logic [OPCODE_W-1:0] OP_ADDI      = 4'b0011;
    localparam logic [OPCODE_W-1:0] OP_SUBI      = 4'b0100;

    // alu pipeline depth
    localparam int ALU_LAT = 3;

    // output fifo size, equal to the upstream credit pool
    localparam int BUF_DEPTH = 8;
    localparam int PTR_W     = $clog2(BUF_DEPTH);

    // credits granted by downstream after reset
    localparam int DOWN_CREDITS = 4;

    typedef logic [CONT_W-1:0]            cont_t;
    typedef logic [NUM_CONT*CONT_W-1:0]   phv_t;
    typedef logic [ACTION_W-1:0]          action_t;
    typedef logic [NUM_CONT*ACTION_W-1:0] action_vec_t;
    typedef logic [OPCODE_W-1:0]          opcode_t;
    typedef logic [SEL_W-1:0]             sel_t;
    typedef logic [IMM_W-1:0]             imm_t;
    typedef logic [PTR_W-1:0]             ptr_t;

    // must hold BUF_DEPTH itself, not only BUF_DEPTH-1
    typedef logic [$clog2(BUF_DEPTH+1)-1:0] credit_cnt_t;

    // operation seen by the alu after decode
    typedef enum logic [1:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB
    } alu_op_t;

endpackage

// File: operand_fetch.sv
// operand fetch and decode
`timescale 1ns/1ns

module operand_fetch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rmt_pkg::phv_t        phv_in,
    input  rmt_pkg::action_vec_t action_in,
    input  logic                 phv_in_valid,
    output logic                 op_valid,
    output rmt_pkg::alu_op_t     alu_op    [rmt_pkg::NUM_CONT],
    output rmt_pkg::cont_t       operand_a [rmt_pkg::NUM_CONT],
    output rmt_pkg::cont_t       operand_b [rmt_pkg::NUM_CONT]
);

    // decoded values ahead of the register
    rmt_pkg::alu_op_t op_nxt [rmt_pkg::NUM_CONT];
    rmt_pkg::cont_t   a_nxt  [rmt_pkg::NUM_CONT];
    rmt_pkg::cont_t   b_nxt  [rmt_pkg::NUM_CONT];

    // split phv into containers, container 0 in the low bits
    rmt_pkg::cont_t   cont_in [rmt_pkg::NUM_CONT];

    always_comb begin
        for (int i = 0; i < rmt_pkg::NUM_CONT; i++) begin
            cont_in[i] = phv_in[i*rmt_pkg::CONT_W +: rmt_pkg::CONT_W];
        end
    end

    always_comb begin
        rmt_pkg::action_t act;
        rmt_pkg::opcode_t opc;
        rmt_pkg::sel_t    sel_a;
        rmt_pkg::sel_t    sel_b;
        rmt_pkg::imm_t    imm;
        for (int i = 0; i < rmt_pkg::NUM_CONT; i++) begin
            act   = action_in[i*rmt_pkg::ACTION_W +: rmt_pkg::ACTION_W];
            opc   = act[rmt_pkg::ACTION_W-1 -: rmt_pkg::OPCODE_W];
            sel_a = act[rmt_pkg::IMM_W+rmt_pkg::SEL_W +: rmt_pkg::SEL_W];
            sel_b = act[rmt_pkg::IMM_W +: rmt_pkg::SEL_W];
            imm   = act[rmt_pkg::IMM_W-1:0];
            // default is the no-op: container keeps its own value
            op_nxt[i] = rmt_pkg::ALU_PASS;
            a_nxt[i]  = cont_in[i];
            b_nxt[i]  = '0;
            case (opc)
                rmt_pkg::OP_ADD, rmt_pkg::OP_ADD_ALIAS: begin
                    op_nxt[i] = rmt_pkg::ALU_ADD;
                    a_nxt[i]  = cont_in[sel_a];
                    b_nxt[i]  = cont_in[sel_b];
                end
                rmt_pkg::OP_SUB, rmt_pkg::OP_SUB_ALIAS: begin
                    op_nxt[i] = rmt_pkg::ALU_SUB;
                    a_nxt[i]  = cont_in[sel_a];
                    b_nxt[i]  = cont_in[sel_b];
                end
                rmt_pkg::OP_ADDI: begin
                    op_nxt[i] = rmt_pkg::ALU_ADD;
                    a_nxt[i]  = cont_in[sel_a];
                    // immediate zero-extended to container width
                    b_nxt[i]  = rmt_pkg::cont_t'(imm);
                end
                rmt_pkg::OP_SUBI: begin
                    op_nxt[i] = rmt_pkg::ALU_SUB;
                    a_nxt[i]  = cont_in[sel_a];
                    b_nxt[i]  = rmt_pkg::cont_t'(imm);
                end
                default: begin
                    // unknown codes fall through as pass
                    op_nxt[i] = rmt_pkg::ALU_PASS;
                end
            endcase
        end
    end

    // one shared valid for all alus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= phv_in_valid;
        end
    end

    // operand payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < rmt_pkg::NUM_CONT; i++) begin
            alu_op[i]    <= op_nxt[i];
            operand_a[i] <= a_nxt[i];
            operand_b[i] <= b_nxt[i];
        end
    end

endmodule

// File: alu.sv
// container alu pipeline
`timescale 1ns/1ns

module alu (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             op_valid,
    input  rmt_pkg::alu_op_t alu_op,
    input  rmt_pkg::cont_t   operand_a,
    input  rmt_pkg::cont_t   operand_b,
    output logic             res_valid,
    output rmt_pkg::cont_t   result
);

    // combinational result, wraps modulo 2^48
    rmt_pkg::cont_t calc;

    // valid and data for each pipeline register
    logic [rmt_pkg::ALU_LAT-1:0] vld_pipe;
    rmt_pkg::cont_t              res_pipe [rmt_pkg::ALU_LAT];

    always_comb begin
        case (alu_op)
            rmt_pkg::ALU_ADD: calc = operand_a + operand_b;
            rmt_pkg::ALU_SUB: calc = operand_a - operand_b;
            default:          calc = operand_a;
        endcase
    end

    // valid shift chain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= op_valid;
            for (int k = 1; k < rmt_pkg::ALU_LAT; k++) begin
                vld_pipe[k] <= vld_pipe[k-1];
            end
        end
    end

    // data follows valid, computed in the first stage only
    always_ff @(posedge clk) begin
        res_pipe[0] <= calc;
        for (int k = 1; k < rmt_pkg::ALU_LAT; k++) begin
            res_pipe[k] <= res_pipe[k-1];
        end
    end

    // last stage drives the outputs
    assign res_valid = vld_pipe[rmt_pkg::ALU_LAT-1];
    assign result    = res_pipe[rmt_pkg::ALU_LAT-1];

endmodule

// File: phv_out_buffer.sv
// phv output buffer with credit flow control
`timescale 1ns/1ns

module phv_out_buffer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           res_valid,
    input  rmt_pkg::cont_t result [rmt_pkg::NUM_CONT],
    input  logic           out_credit,
    output rmt_pkg::phv_t  phv_out,
    output logic           phv_out_valid,
    output logic           in_credit
);

    // fifo storage and bookkeeping
    rmt_pkg::phv_t       mem [rmt_pkg::BUF_DEPTH];
    rmt_pkg::ptr_t       wr_ptr;
    rmt_pkg::ptr_t       rd_ptr;
    rmt_pkg::credit_cnt_t count;

    // downstream credits not yet spent by a sent phv
    rmt_pkg::credit_cnt_t down_cnt;
    rmt_pkg::credit_cnt_t spare;

    rmt_pkg::phv_t res_phv;
    rmt_pkg::phv_t head;
    logic          avail;
    logic          pop;

    // reassemble phv, container 0 in the low bits
    always_comb begin
        for (int i = 0; i < rmt_pkg::NUM_CONT; i++) begin
            res_phv[i*rmt_pkg::CONT_W +: rmt_pkg::CONT_W] = result[i];
        end
    end

    // empty fifo forwards the incoming phv directly
    assign head  = (count == '0) ? res_phv : mem[rd_ptr];
    assign avail = (count != '0) || res_valid;

    // a phv on the output this cycle already holds one credit
    assign spare = down_cnt - rmt_pkg::credit_cnt_t'(phv_out_valid);
    assign pop   = avail && (spare != '0);

    // storage, written on every alu result
    always_ff @(posedge clk) begin
        if (res_valid) begin
            mem[wr_ptr] <= res_phv;
        end
        if (pop) begin
            phv_out <= head;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            down_cnt      <= rmt_pkg::credit_cnt_t'(rmt_pkg::DOWN_CREDITS);
            phv_out_valid <= 1'b0;
        end else begin
            if (res_valid) begin
                wr_ptr <= (wr_ptr == rmt_pkg::ptr_t'(rmt_pkg::BUF_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == rmt_pkg::ptr_t'(rmt_pkg::BUF_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            // a bypassed phv leaves the count unchanged
            count <= count + rmt_pkg::credit_cnt_t'(res_valid)
                           - rmt_pkg::credit_cnt_t'(pop);
            // spend on send, refill on each returned pulse
            down_cnt <= down_cnt - rmt_pkg::credit_cnt_t'(phv_out_valid)
                                 + rmt_pkg::credit_cnt_t'(out_credit);
            phv_out_valid <= pop;
        end
    end

    // slot freed as the phv leaves, so one credit goes back upstream
    assign in_credit = phv_out_valid;

endmodule

// File: action_stage.sv
// rmt action stage top
`timescale 1ns/1ns

module action_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rmt_pkg::phv_t        phv_in,
    input  rmt_pkg::action_vec_t action_in,
    input  logic                 phv_in_valid,
    output logic                 in_credit,
    output rmt_pkg::phv_t        phv_out,
    output logic                 phv_out_valid,
    input  logic                 out_credit
);

    // fetch to alu
    logic             op_valid;
    rmt_pkg::alu_op_t alu_op    [rmt_pkg::NUM_CONT];
    rmt_pkg::cont_t   operand_a [rmt_pkg::NUM_CONT];
    rmt_pkg::cont_t   operand_b [rmt_pkg::NUM_CONT];

    // alu to buffer
    logic [rmt_pkg::NUM_CONT-1:0] res_valid;
    rmt_pkg::cont_t               result [rmt_pkg::NUM_CONT];

    operand_fetch i_operand_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .phv_in       (phv_in),
        .action_in    (action_in),
        .phv_in_valid (phv_in_valid),
        .op_valid     (op_valid),
        .alu_op       (alu_op),
        .operand_a    (operand_a),
        .operand_b    (operand_b)
    );

    // one alu per container, all fed by the same valid
    for (genvar i = 0; i < rmt_pkg::NUM_CONT; i++) begin : g_alu
        alu i_alu (
            .clk       (clk),
            .rst_n     (rst_n),
            .op_valid  (op_valid),
            .alu_op    (alu_op[i]),
            .operand_a (operand_a[i]),
            .operand_b (operand_b[i]),
            .res_valid (res_valid[i]),
            .result    (result[i])
        );
    end

    // alus run in lockstep, alu 0 speaks for all
    phv_out_buffer i_phv_out_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .res_valid     (res_valid[0]),
        .result        (result),
        .out_credit    (out_credit),
        .phv_out       (phv_out),
        .phv_out_valid (phv_out_valid),
        .in_credit     (in_credit)
    );

endmodule

// File: action_stage_sva.sv
// action stage credit and buffer checks
`timescale 1ns/1ns

module action_stage_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 phv_out_valid,
    input logic                 in_credit,
    input logic                 res_valid,
    input rmt_pkg::credit_cnt_t count,
    input rmt_pkg::credit_cnt_t down_cnt
);

    // number of failed properties
    int fail_cnt = 0;

    // never send without a downstream credit in hand
    a_no_send_without_credit : assert property (
        @(posedge clk) disable iff (!rst_n)
        phv_out_valid |-> (down_cnt != '0)
    ) else begin
        $error("phv_out_valid high with zero downstream credit");
        fail_cnt++;
    end

    // fifo occupancy bounded by its depth
    a_count_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= rmt_pkg::credit_cnt_t'(rmt_pkg::BUF_DEPTH)
    ) else begin
        $error("fifo count above BUF_DEPTH");
        fail_cnt++;
    end

    // downstream never gives back more than it granted
    a_down_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        down_cnt <= rmt_pkg::credit_cnt_t'(rmt_pkg::DOWN_CREDITS)
    ) else begin
        $error("downstream credit counter above DOWN_CREDITS");
        fail_cnt++;
    end

    // a credit goes back only for a phv held or bypassed
    a_credit_for_phv : assert property (
        @(posedge clk) disable iff (!rst_n)
        in_credit |-> $past(count != '0 || res_valid)
    ) else begin
        $error("in_credit without a phv in the fifo or bypass");
        fail_cnt++;
    end

    // quiet output right after reset
    a_quiet_after_reset : assert property (
        @(posedge clk)
        $rose(rst_n) |-> !phv_out_valid
    ) else begin
        $error("phv_out_valid high in the cycle after reset");
        fail_cnt++;
    end

endmodule

// File: tb_action_stage.sv
// action stage testbench
`timescale 1ns/1ns

module tb_action_stage;

    // phvs sent over all tests
    localparam int N_PHV     = 2 + 1 + 1 + 20 + rmt_pkg::DOWN_CREDITS + rmt_pkg::BUF_DEPTH;
    localparam int MAX_DELAY = 8;
    localparam int TIMEOUT   = N_PHV * (10 + MAX_DELAY) + 200;
    // downstream credit modes
    localparam int PROMPT = 0;
    localparam int RAND   = 1;
    localparam int HOLD   = 2;

    logic                 clk;
    logic                 rst_n;
    rmt_pkg::phv_t        phv_in;
    rmt_pkg::action_vec_t action_in;
    logic                 phv_in_valid;
    logic                 in_credit;
    rmt_pkg::phv_t        phv_out;
    logic                 phv_out_valid;
    logic                 out_credit;

    integer        seed = 32'h655d_18b8;
    rmt_pkg::phv_t exp_q [$];
    rmt_pkg::phv_t exp_phv;
    int            sent_cnt = 0;
    int            ret_cnt = 0;
    int            recv_cnt = 0;
    int            err_cnt = 0;
    int            test_cnt = 0;
    int            dmode = PROMPT;
    int            owed = 0;
    int            dly = 0;
    int            base;

    action_stage i_action_stage (.*);

    bind phv_out_buffer action_stage_sva i_action_stage_sva (
        .clk(clk), .rst_n(rst_n), .phv_out_valid(phv_out_valid),
        .in_credit(in_credit), .res_valid(res_valid), .count(count), .down_cnt(down_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected phv from the sub-action rules
    function automatic rmt_pkg::phv_t model(rmt_pkg::phv_t p, rmt_pkg::action_vec_t a);
        logic [47:0]   c [4];
        logic [24:0]   act;
        logic [16:0]   imm;
        rmt_pkg::phv_t r;
        for (int i = 0; i < 4; i++) c[i] = p[i*48 +: 48];
        for (int i = 0; i < 4; i++) begin
            act = a[i*25 +: 25];
            imm = act[16:0];
            case (act[24:21])
                4'h1, 4'h9: r[i*48 +: 48] = c[act[20:19]] + c[act[18:17]];
                4'h2, 4'hA: r[i*48 +: 48] = c[act[20:19]] - c[act[18:17]];
                4'h3:       r[i*48 +: 48] = c[act[20:19]] + {31'd0, imm};
                4'h4:       r[i*48 +: 48] = c[act[20:19]] - {31'd0, imm};
                default:    r[i*48 +: 48] = c[i];
            endcase
        end
        return r;
    endfunction

    function automatic rmt_pkg::action_t mk_act(logic [3:0] opc, logic [1:0] sa,
                                                logic [1:0] sb, logic [16:0] imm);
        return {opc, sa, sb, imm};
    endfunction

    function automatic int credits();
        return rmt_pkg::BUF_DEPTH - sent_cnt + ret_cnt;
    endfunction

    // waits for an upstream credit, then sends one phv
    task automatic send_phv(rmt_pkg::phv_t p, rmt_pkg::action_vec_t a);
        @(posedge clk);
        while (credits() == 0) begin
            phv_in_valid <= 1'b0;
            @(posedge clk);
        end
        phv_in       <= p;
        action_in    <= a;
        phv_in_valid <= 1'b1;
        sent_cnt++;
        exp_q.push_back(model(p, a));
    endtask

    task automatic drain(string name);
        @(posedge clk);
        phv_in_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        // let the last credits come home
        while (owed != 0 || out_credit) @(posedge clk);
        // every phv out has given its upstream credit back
        assert (credits() == rmt_pkg::BUF_DEPTH) else begin
            err_cnt++;
            $display("upstream credits not all returned after %s", name);
        end
        test_cnt++;
        $display("test %0d %s done, %0d phvs out so far", test_cnt, name, recv_cnt);
    endtask

    // upstream credit return, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && in_credit) ret_cnt++;
        if (rst_n) begin
            assert (credits() <= rmt_pkg::BUF_DEPTH) else begin
                err_cnt++;
                $display("upstream credits exceed the buffer depth");
            end
        end
        // nothing may leave before the first send
        if (rst_n && sent_cnt == 0) begin
            assert (!phv_out_valid && !in_credit) else begin
                err_cnt++;
                $display("output active before any phv was sent");
            end
        end
    end

    // output check against the expected queue
    always @(posedge clk) begin
        if (rst_n && phv_out_valid) begin
            recv_cnt++;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("phv_out_valid with no phv expected");
            end else begin
                exp_phv = exp_q.pop_front();
                assert (phv_out === exp_phv) else begin
                    err_cnt++;
                    $display("[ERROR] phv_out expected %h actual %h", exp_phv, phv_out);
                end
            end
        end
    end

    // downstream credit model
    always @(posedge clk) begin
        if (!rst_n) begin
            out_credit <= 1'b0;
            owed = 0;
            dly = 0;
        end else begin
            owed = owed + phv_out_valid;
            out_credit <= 1'b0;
            if (dmode != HOLD && owed != 0) begin
                if (dly == 0) begin
                    out_credit <= 1'b1;
                    owed--;
                    if (dmode == RAND) dly = $unsigned($random(seed)) % MAX_DELAY;
                end else begin
                    dly--;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("timeout, the stage stopped delivering phvs");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        phv_in       = '0;
        action_in    = '0;
        phv_in_valid = 1'b0;
        out_credit   = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (6) @(posedge clk);

        // register ops, own source, alias codes, wrap
        dmode = RAND;
        send_phv({48'h1, 48'h1234_5678_9ABC, 48'h20, 48'hFFFF_FFFF_FFF0},
                 {mk_act(4'hA, 0, 3, 0), mk_act(4'h9, 2, 2, 0),
                  mk_act(4'h2, 3, 1, 0), mk_act(4'h1, 0, 1, 0)});
        send_phv({48'h7, 48'h0, 48'hFFFF_FFFF_FFFF, 48'h5},
                 {mk_act(4'h1, 3, 3, 0), mk_act(4'h2, 1, 0, 0),
                  mk_act(4'h9, 1, 3, 0), mk_act(4'hA, 2, 0, 0)});
        drain("register add/sub");

        // immediates, zero extension and wrap below zero
        send_phv({48'h10, 48'h0, 48'hFFFF_FFFF_0000, 48'h3},
                 {mk_act(4'h4, 3, 0, 17'h11), mk_act(4'h3, 2, 0, 17'h1FFFF),
                  mk_act(4'h4, 1, 0, 17'h1), mk_act(4'h3, 0, 2, 17'h10000)});
        drain("immediate addi/subi");

        // no-op and undefined codes keep their container
        send_phv({48'hDDDD, 48'hCCCC, 48'hBBBB, 48'hAAAA},
                 {mk_act(4'h5, 0, 1, 17'h3), mk_act(4'h1, 0, 1, 0),
                  mk_act(4'hF, 2, 3, 17'h7), mk_act(4'h0, 1, 2, 17'h9)});
        drain("no-op codes");

        // back to back, prompt credits
        dmode = PROMPT;
        repeat (20) begin
            send_phv({$random(seed), $random(seed), $random(seed), $random(seed),
                      $random(seed), $random(seed)},
                     {rmt_pkg::action_t'($random(seed)), rmt_pkg::action_t'($random(seed)),
                      rmt_pkg::action_t'($random(seed)), rmt_pkg::action_t'($random(seed))});
        end
        drain("back to back");

        // back-pressure, credits withheld
        dmode = HOLD;
        base = recv_cnt;
        repeat (rmt_pkg::DOWN_CREDITS + rmt_pkg::BUF_DEPTH) begin
            send_phv({$random(seed), $random(seed), $random(seed), $random(seed),
                      $random(seed), $random(seed)},
                     {rmt_pkg::action_t'($random(seed)), rmt_pkg::action_t'($random(seed)),
                      rmt_pkg::action_t'($random(seed)), rmt_pkg::action_t'($random(seed))});
        end
        @(posedge clk);
        phv_in_valid <= 1'b0;
        repeat (40) @(posedge clk);
        assert (recv_cnt - base == rmt_pkg::DOWN_CREDITS && credits() == 0) else begin
            err_cnt++;
            $display("back-pressure did not hold the expected phvs and credits");
        end
        dmode = PROMPT;
        drain("back-pressure");

        err_cnt = err_cnt + i_action_stage.i_phv_out_buffer.i_action_stage_sva.fail_cnt;
        if (err_cnt == 0 && exp_q.size() == 0) begin
            $display("tests %0d, phvs %0d, errors %0d", test_cnt, recv_cnt, err_cnt);
            $display(">>> PASS");
        end else begin
            $display("tests %0d, phvs %0d, errors %0d", test_cnt, recv_cnt, err_cnt);
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
rmt_pkg.sv
operand_fetch.sv
alu.sv
phv_out_buffer.sv
action_stage.sv
action_stage_sva.sv
tb_action_stage.sv
